/* rtl/cpuPkg.sv */
package cpuPkg;

    // ====================
    // widths
    // ====================
    localparam int xlen     = 32;   // data and address width
    localparam int regAddrW = 5;    // register index width

    // ====================
    // encodings
    // ====================
    typedef enum logic [6:0] {
        opLui    = 7'd55,
        opOp     = 7'd51,
        opOpImm  = 7'd19,
        opBranch = 7'd99,
        opJalr   = 7'd103,
        opJal    = 7'd111,
        opLoad   = 7'd3,
        opStore  = 7'd35
    } opcode_e;

    typedef enum logic [2:0] {      // codes match funct3
        aluAdd = 3'b000,
        aluSll = 3'b001,
        aluXor = 3'b100,
        aluSrl = 3'b101,
        aluAnd = 3'b111
    } aluOp_e;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPcPlus4                  // link value for jal and jalr
    } resultSrc_e;

    typedef enum logic [2:0] {
        memNone,
        memLw,
        memLb,
        memLbu,
        memSw,
        memSb
    } memOp_e;

    typedef enum logic [2:0] {
        flowNone,
        flowBeq,
        flowBne,
        flowBlt,
        flowBge,
        flowJal,
        flowJalr
    } flowOp_e;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immSel_e;

    // ====================
    // bundles
    // ====================
    typedef struct packed {
        logic       regWrite;
        resultSrc_e resultSrc;
        memOp_e     memOp;
        flowOp_e    flowOp;
        aluOp_e     aluOp;
        logic       aluSrcImm;      // operand b from imm
        immSel_e    immSel;
        logic       zeroA;          // operand a forced to zero (lui)
    } ctrl_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     rs1Val;
        logic [xlen-1:0]     rs2Val;
        logic [xlen-1:0]     imm;
        logic [regAddrW-1:0] rd;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [regAddrW-1:0] rd;
        logic                regWrite;
        logic [xlen-1:0]     writeData;
    } retire_t;

    typedef struct packed {
        logic                en;
        logic [regAddrW-1:0] addr;
        logic [xlen-1:0]     data;
    } regWrite_t;

    // all-inactive bundle
    localparam ctrl_t ctrlNop = '{
        regWrite:  1'b0,
        resultSrc: resAlu,
        memOp:     memNone,
        flowOp:    flowNone,
        aluOp:     aluAdd,
        aluSrcImm: 1'b0,
        immSel:    immI,
        zeroA:     1'b0
    };

endpackage

/* rtl/controlUnit.sv */
module controlUnit (
    input  logic [6:0]    op,
    input  logic [2:0]    funct3,
    input  logic          funct7,
    output cpuPkg::ctrl_t ctrl
);

    always_comb begin
        ctrl = cpuPkg::ctrlNop;                     // anything unmatched is a no-op
        case (cpuPkg::opcode_e'(op))
            // ====================
            // alu types
            // ====================
            cpuPkg::opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = cpuPkg::immU;
                ctrl.zeroA     = 1'b1;              // 0 + upper imm
            end
            cpuPkg::opOp: begin
                if (!funct7) begin                  // sub and sra not supported
                    case (funct3)
                        3'b000:  ctrl.aluOp = cpuPkg::aluAdd;
                        3'b001:  ctrl.aluOp = cpuPkg::aluSll;
                        3'b100:  ctrl.aluOp = cpuPkg::aluXor;
                        3'b101:  ctrl.aluOp = cpuPkg::aluSrl;
                        3'b111:  ctrl.aluOp = cpuPkg::aluAnd;
                        default: ctrl.aluOp = cpuPkg::aluAdd;
                    endcase
                    ctrl.regWrite = funct3 inside {3'b000, 3'b001, 3'b100, 3'b101, 3'b111};
                end
            end
            cpuPkg::opOpImm: begin
                if (funct3 == 3'b000) begin         // addi only
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.immSel    = cpuPkg::immI;
                end
            end
            // ====================
            // control flow
            // ====================
            cpuPkg::opBranch: begin
                case (funct3)
                    3'b000:  ctrl.flowOp = cpuPkg::flowBeq;
                    3'b001:  ctrl.flowOp = cpuPkg::flowBne;
                    3'b100:  ctrl.flowOp = cpuPkg::flowBlt;
                    3'b101:  ctrl.flowOp = cpuPkg::flowBge;
                    default: ctrl.flowOp = cpuPkg::flowNone;
                endcase
                ctrl.immSel = cpuPkg::immB;         // compare on rs1 vs rs2
            end
            cpuPkg::opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = cpuPkg::resPcPlus4;
                ctrl.flowOp    = cpuPkg::flowJalr;
                ctrl.aluSrcImm = 1'b1;              // alu gives rs1 + imm
                ctrl.immSel    = cpuPkg::immI;
            end
            cpuPkg::opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = cpuPkg::resPcPlus4;
                ctrl.flowOp    = cpuPkg::flowJal;
                ctrl.immSel    = cpuPkg::immJ;
            end
            // ====================
            // memory
            // ====================
            cpuPkg::opLoad: begin
                case (funct3)
                    3'b010:  ctrl.memOp = cpuPkg::memLw;
                    3'b000:  ctrl.memOp = cpuPkg::memLb;
                    3'b100:  ctrl.memOp = cpuPkg::memLbu;
                    default: ctrl.memOp = cpuPkg::memNone;
                endcase
                if (ctrl.memOp != cpuPkg::memNone) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.resultSrc = cpuPkg::resMem;
                    ctrl.aluSrcImm = 1'b1;          // address = rs1 + imm
                    ctrl.immSel    = cpuPkg::immI;
                end
            end
            cpuPkg::opStore: begin
                case (funct3)
                    3'b010:  ctrl.memOp = cpuPkg::memSw;
                    3'b000:  ctrl.memOp = cpuPkg::memSb;
                    default: ctrl.memOp = cpuPkg::memNone;
                endcase
                if (ctrl.memOp != cpuPkg::memNone) begin
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.immSel    = cpuPkg::immS;
                end
            end
            default: ctrl = cpuPkg::ctrlNop;
        endcase
    end

endmodule

/* rtl/regFile.sv */
module regFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [cpuPkg::regAddrW-1:0]   rs1Addr,
    input  logic [cpuPkg::regAddrW-1:0]   rs2Addr,
    output logic [cpuPkg::xlen-1:0]       rs1Data,
    output logic [cpuPkg::xlen-1:0]       rs2Data,
    input  cpuPkg::regWrite_t             wbPort
);

    logic [cpuPkg::xlen-1:0] regs [32];    // entry 0 never written

    function automatic logic [cpuPkg::xlen-1:0] readPort(
        input logic [cpuPkg::regAddrW-1:0] addr,
        input logic [cpuPkg::xlen-1:0]     stored,
        input cpuPkg::regWrite_t           wr
    );
        logic [cpuPkg::xlen-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wr.en && wr.addr == addr) begin
            value = wr.data;                 // same-cycle write passes through
        end else begin
            value = stored;
        end
        return value;
    endfunction

    assign rs1Data = readPort(rs1Addr, regs[rs1Addr], wbPort);
    assign rs2Data = readPort(rs2Addr, regs[rs2Addr], wbPort);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbPort.en && wbPort.addr != '0) begin
            regs[wbPort.addr] <= wbPort.data;
        end
    end

    // an x0 write from execute must not leak through the bypass
    assert property (@(posedge clk) disable iff (!rstN)
        (wbPort.en && wbPort.addr == '0) |->
            (rs1Addr != '0 || rs1Data == '0) && (rs2Addr != '0 || rs2Data == '0))
        else $error("write to x0 was accepted");

endmodule

/* rtl/decodeStage.sv */
module decodeStage (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          instrValid,
    input  logic [31:0]                   instr,
    input  logic [cpuPkg::xlen-1:0]       pc,
    output logic [cpuPkg::regAddrW-1:0]   rs1Addr,
    output logic [cpuPkg::regAddrW-1:0]   rs2Addr,
    input  logic [cpuPkg::xlen-1:0]       rs1Data,
    input  logic [cpuPkg::xlen-1:0]       rs2Data,
    output logic                          exValid,
    output cpuPkg::decoded_t              exData
);

    logic [6:0]                    opField;
    logic [2:0]                    funct3;
    logic                          funct7;
    logic [cpuPkg::regAddrW-1:0]   rdField;
    logic [cpuPkg::xlen-1:0]       imm;
    logic                          opLegal;
    cpuPkg::ctrl_t                 ctrl;
    cpuPkg::decoded_t              decoded;

    // ====================
    // field slicing
    // ====================
    assign opField = instr[6:0];
    assign rdField = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1Addr = instr[19:15];    // read requests go straight to regFile
    assign rs2Addr = instr[24:20];
    assign funct7  = instr[30];       // only bit that differs for sub/sra

    assign opLegal = opField inside {cpuPkg::opLui, cpuPkg::opOp, cpuPkg::opOpImm,
                                     cpuPkg::opBranch, cpuPkg::opJalr, cpuPkg::opJal,
                                     cpuPkg::opLoad, cpuPkg::opStore};

    controlUnit ctrl0 (
        .op     (opField),
        .funct3 (funct3),
        .funct7 (funct7),
        .ctrl   (ctrl)
    );

    // immediate build, all sign extended from bit 31
    always_comb begin
        case (ctrl.immSel)
            cpuPkg::immI: imm = {{20{instr[31]}}, instr[31:20]};
            cpuPkg::immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cpuPkg::immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
            cpuPkg::immU: imm = {instr[31:12], 12'b0};
            cpuPkg::immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                 instr[30:21], 1'b0};
            default:      imm = '0;
        endcase
    end

    always_comb begin
        decoded.ctrl   = ctrl;
        decoded.pc     = pc;
        decoded.rs1Val = rs1Data;     // already bypassed by regFile
        decoded.rs2Val = rs2Data;
        decoded.imm    = imm;
        decoded.rd     = rdField;
    end

    // ====================
    // decode to execute
    // ====================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            exData <= decoded;
        end
    end

    // unknown opcodes must not reach execute with a register write
    assert property (@(posedge clk) disable iff (!rstN)
        exValid |-> ($past(opLegal) || !exData.ctrl.regWrite))
        else $error("decode passed a register write for an unknown opcode");

endmodule

/* rtl/executeStage.sv */
module executeStage #(
    parameter int dmemWords = 256
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      exValid,
    input  cpuPkg::decoded_t          exData,
    output cpuPkg::regWrite_t         wbPort,
    output logic                      retireValid,
    output cpuPkg::retire_t           retireInfo,
    output logic                      redirectValid,
    output logic [cpuPkg::xlen-1:0]   redirectTarget
);

    localparam int dmemAw = $clog2(dmemWords);

    logic [cpuPkg::xlen-1:0] opA;
    logic [cpuPkg::xlen-1:0] opB;
    logic [cpuPkg::xlen-1:0] aluRes;
    logic [cpuPkg::xlen-1:0] pcPlus4;
    logic [cpuPkg::xlen-1:0] target;
    logic [cpuPkg::xlen-1:0] memWord;
    logic [cpuPkg::xlen-1:0] loadData;
    logic [cpuPkg::xlen-1:0] result;
    logic [7:0]              loadByte;
    logic [dmemAw-1:0]       wordIdx;
    logic [1:0]              byteSel;
    logic                    isEqual;
    logic                    isLess;
    logic                    taken;

    logic [cpuPkg::xlen-1:0] dmem [dmemWords];

    // ====================
    // alu
    // ====================
    assign opA = exData.ctrl.zeroA ? '0 : exData.rs1Val;
    assign opB = exData.ctrl.aluSrcImm ? exData.imm : exData.rs2Val;

    always_comb begin
        case (exData.ctrl.aluOp)
            cpuPkg::aluAdd: aluRes = opA + opB;
            cpuPkg::aluSll: aluRes = opA << opB[4:0];
            cpuPkg::aluXor: aluRes = opA ^ opB;
            cpuPkg::aluSrl: aluRes = opA >> opB[4:0];    // logical shift
            cpuPkg::aluAnd: aluRes = opA & opB;
            default:        aluRes = '0;
        endcase
    end

    // ====================
    // branch and jump
    // ====================
    assign isEqual = exData.rs1Val == exData.rs2Val;
    assign isLess  = $signed(exData.rs1Val) < $signed(exData.rs2Val);

    always_comb begin
        case (exData.ctrl.flowOp)
            cpuPkg::flowBeq:  taken = isEqual;
            cpuPkg::flowBne:  taken = !isEqual;
            cpuPkg::flowBlt:  taken = isLess;
            cpuPkg::flowBge:  taken = !isLess;
            cpuPkg::flowJal,
            cpuPkg::flowJalr: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign pcPlus4 = exData.pc + cpuPkg::xlen'(4);
    assign target  = (exData.ctrl.flowOp == cpuPkg::flowJalr) ?
                     {aluRes[cpuPkg::xlen-1:1], 1'b0} :       // rs1 + imm, bit 0 cleared
                     exData.pc + exData.imm;

    // ====================
    // data memory
    // ====================
    assign wordIdx  = aluRes[2 +: dmemAw];    // wraps at dmemWords
    assign byteSel  = aluRes[1:0];
    assign memWord  = dmem[wordIdx];
    assign loadByte = memWord[{byteSel, 3'b000} +: 8];

    always_comb begin
        case (exData.ctrl.memOp)
            cpuPkg::memLw:  loadData = memWord;
            cpuPkg::memLb:  loadData = {{24{loadByte[7]}}, loadByte};
            cpuPkg::memLbu: loadData = {24'b0, loadByte};
            default:        loadData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (exValid) begin
            case (exData.ctrl.memOp)
                cpuPkg::memSw: dmem[wordIdx] <= exData.rs2Val;
                cpuPkg::memSb: dmem[wordIdx][{byteSel, 3'b000} +: 8] <= exData.rs2Val[7:0];
                default: ;
            endcase
        end
    end

    // ====================
    // writeback and retire
    // ====================
    always_comb begin
        case (exData.ctrl.resultSrc)
            cpuPkg::resMem:     result = loadData;
            cpuPkg::resPcPlus4: result = pcPlus4;
            default:            result = aluRes;
        endcase
    end

    assign wbPort.en   = exValid && exData.ctrl.regWrite;
    assign wbPort.addr = exData.rd;
    assign wbPort.data = result;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retireValid   <= 1'b0;
            redirectValid <= 1'b0;
        end else begin
            retireValid   <= exValid;
            redirectValid <= exValid && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (exValid) begin
            retireInfo.pc        <= exData.pc;
            retireInfo.regWrite  <= exData.ctrl.regWrite;
            retireInfo.rd        <= exData.ctrl.regWrite ? exData.rd : '0;  // zero when no write
            retireInfo.writeData <= exData.ctrl.regWrite ? result : '0;
            redirectTarget       <= target;
        end
    end

    // a store never writes a register
    assert property (@(posedge clk) disable iff (!rstN)
        (exValid && exData.ctrl.memOp inside {cpuPkg::memSw, cpuPkg::memSb}) |-> !wbPort.en)
        else $error("store drove a register write");

endmodule

/* rtl/cpuCore.sv */
module cpuCore #(
    parameter int dmemWords = 256
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      instrValid,
    input  logic [31:0]               instr,
    input  logic [cpuPkg::xlen-1:0]   pc,
    output logic                      retireValid,
    output cpuPkg::retire_t           retireInfo,
    output logic                      redirectValid,
    output logic [cpuPkg::xlen-1:0]   redirectTarget
);

    logic [cpuPkg::regAddrW-1:0] rs1Addr;
    logic [cpuPkg::regAddrW-1:0] rs2Addr;
    logic [cpuPkg::xlen-1:0]     rs1Data;
    logic [cpuPkg::xlen-1:0]     rs2Data;
    logic                        exValid;
    cpuPkg::decoded_t            exData;
    cpuPkg::regWrite_t           wbPort;     // execute to regFile, combinational

    decodeStage decode0 (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .exValid    (exValid),
        .exData     (exData)
    );

    regFile regs0 (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wbPort  (wbPort)
    );

    executeStage #(
        .dmemWords (dmemWords)
    ) execute0 (
        .clk            (clk),
        .rstN           (rstN),
        .exValid        (exValid),
        .exData         (exData),
        .wbPort         (wbPort),
        .retireValid    (retireValid),
        .retireInfo     (retireInfo),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget)
    );

endmodule

/* dv/coreTbTable.svh */
`ifndef coreTbTableSvh
`define coreTbTableSvh

// columns: instr, pc, noGap (issue right after the previous entry), expected regWrite, rd,
// writeData, redirect flag, redirect target
typedef struct packed {
    logic [31:0]               instr;
    logic [cpuPkg::xlen-1:0]   pc;
    logic                      noGap;
    logic                      regWrite;
    logic [cpuPkg::regAddrW-1:0] rd;
    logic [cpuPkg::xlen-1:0]   writeData;
    logic                      redirect;
    logic [cpuPkg::xlen-1:0]   target;
} stimEntry_t;

localparam int numEntries = 30;

localparam stimEntry_t stimTable [numEntries] = '{
    '{32'h123450B7, 32'h00, 1'b0, 1'b1, 5'd1,  32'h12345000, 1'b0, 32'h0},  // lui x1,0x12345
    '{32'hFFB00113, 32'h04, 1'b0, 1'b1, 5'd2,  32'hFFFFFFFB, 1'b0, 32'h0},  // addi x2,x0,-5
    '{32'h0F000193, 32'h08, 1'b0, 1'b1, 5'd3,  32'h000000F0, 1'b0, 32'h0},  // addi x3,x0,0xf0
    '{32'h00308233, 32'h0C, 1'b1, 1'b1, 5'd4,  32'h123450F0, 1'b0, 32'h0},  // add x4,x1,x3
    '{32'hFFF20293, 32'h10, 1'b1, 1'b1, 5'd5,  32'h123450EF, 1'b0, 32'h0},  // addi x5,x4,-1
    '{32'h00400393, 32'h14, 1'b0, 1'b1, 5'd7,  32'h00000004, 1'b0, 32'h0},  // addi x7,x0,4
    '{32'h00719333, 32'h18, 1'b1, 1'b1, 5'd6,  32'h00000F00, 1'b0, 32'h0},  // sll x6,x3,x7
    '{32'h00715433, 32'h1C, 1'b0, 1'b1, 5'd8,  32'h0FFFFFFF, 1'b0, 32'h0},  // srl x8,x2,x7
    '{32'h0020C4B3, 32'h20, 1'b0, 1'b1, 5'd9,  32'hEDCBAFFB, 1'b0, 32'h0},  // xor x9,x1,x2
    '{32'h0022F533, 32'h24, 1'b0, 1'b1, 5'd10, 32'h123450EB, 1'b0, 32'h0},  // and x10,x5,x2
    '{32'h00508013, 32'h28, 1'b0, 1'b1, 5'd0,  32'h12345005, 1'b0, 32'h0},  // addi x0,x1,5
    '{32'h00700593, 32'h2C, 1'b1, 1'b1, 5'd11, 32'h00000007, 1'b0, 32'h0},  // addi x11,x0,7
    '{32'h00102423, 32'h30, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0},  // sw x1,8(x0)
    '{32'h00802603, 32'h34, 1'b1, 1'b1, 5'd12, 32'h12345000, 1'b0, 32'h0},  // lw x12,8(x0)
    '{32'h002006A3, 32'h38, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0},  // sb x2,13(x0)
    '{32'h00D00683, 32'h3C, 1'b1, 1'b1, 5'd13, 32'hFFFFFFFB, 1'b0, 32'h0},  // lb x13,13(x0)
    '{32'h00D04703, 32'h40, 1'b0, 1'b1, 5'd14, 32'h000000FB, 1'b0, 32'h0},  // lbu x14,13(x0)
    '{32'h00318863, 32'h44, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h54},  // beq x3,x3,+16
    '{32'h00308863, 32'h48, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0},  // beq x1,x3,+16
    '{32'hFE309CE3, 32'h4C, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h44},  // bne x1,x3,-8
    '{32'h00319463, 32'h50, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0},  // bne x3,x3,+8
    '{32'h00314663, 32'h54, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h60},  // blt x2,x3,+12
    '{32'h0021C663, 32'h58, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0},  // blt x3,x2,+12
    '{32'h0021DA63, 32'h5C, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b1, 32'h70},  // bge x3,x2,+20
    '{32'h00315A63, 32'h60, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0},  // bge x2,x3,+20
    '{32'h100007EF, 32'h64, 1'b0, 1'b1, 5'd15, 32'h00000068, 1'b1, 32'h164}, // jal x15,+0x100
    '{32'h00308867, 32'h68, 1'b0, 1'b1, 5'd16, 32'h0000006C, 1'b1, 32'h12345002}, // jalr x16,3(x1)
    '{32'h40308933, 32'h6C, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0},  // sub, unsupported
    '{32'hFFFFFFFF, 32'h70, 1'b0, 1'b0, 5'd0,  32'h00000000, 1'b0, 32'h0},  // bad opcode
    '{32'h001909B3, 32'h74, 1'b0, 1'b1, 5'd19, 32'h12345000, 1'b0, 32'h0}   // add x19,x18,x1
};

`endif

/* dv/coreTb.sv */
module coreTb;

    `include "coreTbTable.svh"

    localparam int dmemWords     = 256;
    localparam int drvDelay      = 1;                       // after the rising edge
    localparam int retireLatency = 2;
    localparam int timeoutCycles = 4 * numEntries + 50;
    localparam int drainLimit    = 10;

    typedef struct {
        int                      idx;
        int                      dueCycle;
        cpuPkg::retire_t         retire;
        logic                    redirect;
        logic [cpuPkg::xlen-1:0] target;
    } expect_t;

    logic                    clk;
    logic                    rstN;
    logic                    instrValid;
    logic [31:0]             instr;
    logic [cpuPkg::xlen-1:0] pc;
    logic                    retireValid;
    cpuPkg::retire_t         retireInfo;
    logic                    redirectValid;
    logic [cpuPkg::xlen-1:0] redirectTarget;

    expect_t pending [$];                                   // scoreboard, oldest first
    int      cycleCount = 0;

    cpuCore #(
        .dmemWords (dmemWords)
    ) dut0 (
        .clk            (clk),
        .rstN           (rstN),
        .instrValid     (instrValid),
        .instr          (instr),
        .pc             (pc),
        .retireValid    (retireValid),
        .retireInfo     (retireInfo),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ====================
    // failure reporting
    // ====================
    task automatic abortRun();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        abortRun();
    endtask

    task automatic reportProblem(input string msg);
        $display("At time %0t the run stopped: %s", $time, msg);
        abortRun();
    endtask

    task automatic checkRetire(input cpuPkg::retire_t got, input cpuPkg::retire_t exp,
                               input int idx);
        if (got !== exp) begin
            reportMismatch($sformatf(
                "entry %0d retire pc=%h rd=%0d we=%b data=%h, expected pc=%h rd=%0d we=%b data=%h",
                idx, got.pc, got.rd, got.regWrite, got.writeData,
                exp.pc, exp.rd, exp.regWrite, exp.writeData));
        end
    endtask

    task automatic checkRedirect(input logic gotValid, input logic [cpuPkg::xlen-1:0] gotTarget,
                                 input logic expValid, input logic [cpuPkg::xlen-1:0] expTarget,
                                 input int idx);
        if (gotValid !== expValid) begin
            reportMismatch($sformatf("entry %0d redirect %b, expected %b",
                                     idx, gotValid, expValid));
        end else if (expValid && gotTarget !== expTarget) begin
            reportMismatch($sformatf("entry %0d redirect target %h, expected %h",
                                     idx, gotTarget, expTarget));
        end
    endtask

    // ====================
    // cycle count and timeout
    // ====================
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            reportProblem($sformatf("timeout after %0d cycles", timeoutCycles));
        end
    end

    // ====================
    // driver
    // ====================
    initial begin
        expect_t exp;
        int      idle;
        int      drainWait;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        void'($urandom(38));
        repeat (5) @(posedge clk);
        #drvDelay rstN = 1'b1;
        @(posedge clk);
        #drvDelay;
        for (int i = 0; i < numEntries; i++) begin
            idle = stimTable[i].noGap ? 0 : int'($urandom % 3);
            repeat (idle) begin
                instrValid = 1'b0;
                @(posedge clk);
                #drvDelay;
            end
            instrValid = 1'b1;
            instr      = stimTable[i].instr;
            pc         = stimTable[i].pc;
            exp.idx              = i;
            exp.dueCycle         = cycleCount + retireLatency;  // sampled at the negedge
            exp.retire.pc        = stimTable[i].pc;
            exp.retire.rd        = stimTable[i].rd;
            exp.retire.regWrite  = stimTable[i].regWrite;
            exp.retire.writeData = stimTable[i].writeData;
            exp.redirect         = stimTable[i].redirect;
            exp.target           = stimTable[i].target;
            pending.push_back(exp);
            @(posedge clk);
            #drvDelay;
        end
        instrValid = 1'b0;
        drainWait  = 0;
        while (pending.size() != 0 && drainWait < drainLimit) begin
            @(posedge clk);
            drainWait++;
        end
        @(negedge clk);
        if (pending.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            reportProblem($sformatf("%0d instructions never retired", pending.size()));
        end
    end

    // ====================
    // monitor
    // ====================
    always @(negedge clk) begin
        expect_t head;
        if (rstN) begin
            if (retireValid) begin
                if (pending.size() == 0) begin
                    reportProblem("a retire came with no instruction outstanding");
                end else begin
                    head = pending.pop_front();
                    if (cycleCount != head.dueCycle) begin
                        reportMismatch($sformatf("entry %0d retired at cycle %0d, expected %0d",
                                                 head.idx, cycleCount, head.dueCycle));
                    end
                    checkRetire(retireInfo, head.retire, head.idx);
                    checkRedirect(redirectValid, redirectTarget, head.redirect, head.target,
                                  head.idx);
                end
            end else if (redirectValid) begin
                reportProblem("a redirect came without a retiring instruction");
            end else if (pending.size() != 0 && cycleCount >= pending[0].dueCycle) begin
                reportProblem($sformatf("entry %0d did not retire on time", pending[0].idx));
            end
        end
    end

endmodule

/* files.f */
+incdir+dv
rtl/cpuPkg.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/cpuCore.sv
dv/coreTb.sv
